/* vlog.f */
logic/gb_timer_pkg.sv
logic/timer_regs_if.sv
logic/apb_timer_regs.sv
logic/sys_divider.sv
logic/tima_counter.sv
logic/timer_irq_out.sv
logic/gb_timer_top.sv
tests/gb_timer_sva.sv
tests/tb_gb_timer.sv

/* Bender.yml */
package:
  name: gb_timer

sources:
  - files:
      - logic/gb_timer_pkg.sv
      - logic/timer_regs_if.sv
      - logic/apb_timer_regs.sv
      - logic/sys_divider.sv
      - logic/tima_counter.sv
      - logic/timer_irq_out.sv
      - logic/gb_timer_top.sv
  - target: test
    files:
      - tests/gb_timer_sva.sv
      - tests/tb_gb_timer.sv

/* tests/tb_gb_timer.sv */
`timescale 1ns/1ps

module tb_gb_timer import gb_timer_pkg::*; ();

	localparam int WAIT_LIMIT = 20000;
	// The audio tap at bit 12 falls once every 2^13 cycles.
	localparam int APU_PERIOD = 1 << 13;

	logic       clkin_a;
	logic       rst_n;
	logic       psel;
	logic       penable;
	logic       pwrite;
	logic [3:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic       pready;
	logic       pslverr;
	logic       irq_ack;
	logic       irq;
	logic       apu_tick;

	int errors = 0;
	int errors_at_start = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	bind gb_timer_top gb_timer_sva u_sva (.clkin_a(clkin_a), .rst_n(rst_n), .psel(psel),
		.penable(penable), .pready(pready), .pslverr(pslverr), .irq_ack(irq_ack),
		.overflow(overflow), .irq(irq), .apu_tick(apu_tick));

	gb_timer_top DUT (.*);

	always #10 clkin_a = ~clkin_a;

	task automatic stop_on_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	// Passes when actual lies between expected minus slack and expected.
	task automatic check_value(input string name, input int expected, input int actual,
			input int slack = 0);
		assert (actual <= expected && actual >= expected - slack)
		else begin
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s %s", name, (errors == errors_at_start) ? "passed" : "failed");
		if (errors == errors_at_start)
			tests_passed++;
		else
			tests_failed++;
		errors_at_start = errors;
	endtask

	task automatic apb_transfer(input logic write, input logic [3:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
		int n;
		n = 0;
		@(negedge clkin_a);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clkin_a);
		penable = 1'b1;
		#1;
		while (!pready) begin
			if (n == WAIT_LIMIT)
				stop_on_timeout("pready");
			@(negedge clkin_a);
			#1;
			n++;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clkin_a);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
		logic [7:0] unused_rd;
		logic       unused_err;
		apb_transfer(1'b1, addr, data, unused_rd, unused_err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [7:0] data, output logic err);
		apb_transfer(1'b0, addr, 8'h00, data, err);
	endtask

	// Counts falling edges until irq, or apu_tick, is seen high.
	task automatic count_until_high(input logic on_apu_tick, output int cycles);
		cycles = 0;
		do begin
			@(negedge clkin_a);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_timeout(on_apu_tick ? "apu_tick" : "irq");
		end while (!(on_apu_tick ? apu_tick : irq));
	endtask

	initial begin
		logic [7:0]  rd;
		logic        err;
		logic [7:0]  rnd;
		int          wait_cycles;
		int          cycles;
		void'($urandom(32'hbad826ba));
		clkin_a = 1'b0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 4'h0;
		pwdata  = 8'h00;
		irq_ack = 1'b0;
		repeat (16) @(negedge clkin_a);
		rst_n = 1'b1;

		apb_read(REG_DIV, rd, err);
		check_value("DIV", 8'h00, rd);
		apb_read(REG_TIMA, rd, err);
		check_value("TIMA", 8'h00, rd);
		apb_read(REG_TMA, rd, err);
		check_value("TMA", 8'h00, rd);
		apb_read(REG_TAC, rd, err);
		check_value("TAC", 8'hF8, rd);
		check_value("irq", 0, irq);
		finish_test("reset_state");

		rnd = $urandom;
		apb_write(REG_TMA, rnd);
		apb_read(REG_TMA, rd, err);
		check_value("TMA", rnd, rd);
		rnd = $urandom;
		apb_write(REG_TAC, rnd);
		apb_read(REG_TAC, rd, err);
		check_value("TAC", (rnd & 8'h07) | 8'hF8, rd);
		apb_write(REG_TAC, 8'h00);
		apb_read(4'h5, rd, err);
		check_value("pslverr", 1, err);
		finish_test("readback_errors");

		// The read samples DIV two edges after the wait ends.
		wait_cycles = 300 + ($urandom % 2000);
		apb_write(REG_DIV, 8'h00);
		repeat (wait_cycles) @(negedge clkin_a);
		apb_read(REG_DIV, rd, err);
		check_value("DIV", (wait_cycles + 2) / 256, rd);
		finish_test("div_count");

		// Select 1 taps bit 3 and steps TIMA once every 16 cycles after the DIV clear.
		apb_write(REG_TAC, 8'h05);
		apb_write(REG_DIV, 8'h00);
		apb_write(REG_TIMA, 8'h00);
		wait_cycles = 320 + ($urandom % 3000);
		repeat (wait_cycles) @(negedge clkin_a);
		apb_read(REG_TIMA, rd, err);
		check_value("TIMA", (wait_cycles + 5) / 16, rd, 1);
		finish_test("tima_rate");

		apb_write(REG_TMA, 8'hF0);
		apb_write(REG_TIMA, 8'hFE);
		count_until_high(1'b0, cycles);
		apb_read(REG_TIMA, rd, err);
		check_value("TIMA", 8'hF1, rd, 1);
		@(negedge clkin_a);
		irq_ack = 1'b1;
		@(negedge clkin_a);
		irq_ack = 1'b0;
		check_value("irq", 0, irq);
		apb_write(REG_TAC, 8'h00);
		finish_test("overflow_irq");

		count_until_high(1'b1, cycles);
		count_until_high(1'b1, cycles);
		check_value("apu_tick interval", APU_PERIOD, cycles);
		finish_test("apu_tick");

		$display("Tests passed %0d, failed %0d, assertion failures %0d",
			tests_passed, tests_failed, DUT.u_sva.sva_errors);
		if (tests_failed == 0 && DUT.u_sva.sva_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tests/gb_timer_sva.sv */
`timescale 1ns/1ps

module gb_timer_sva (
	input logic clkin_a,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic irq_ack,
	input logic overflow,
	input logic irq,
	input logic apu_tick
);

	int sva_errors = 0;

	pready_high: assert property (@(posedge clkin_a) disable iff (!rst_n) pready)
		else begin
			$error("pready went low");
			sva_errors++;
		end

	pslverr_in_access: assert property (@(posedge clkin_a) disable iff (!rst_n)
		!(psel && penable) |-> !pslverr)
		else begin
			$error("pslverr raised outside an access phase");
			sva_errors++;
		end

	apu_tick_single: assert property (@(posedge clkin_a) disable iff (!rst_n)
		apu_tick |=> !apu_tick)
		else begin
			$error("apu_tick lasted more than one cycle");
			sva_errors++;
		end

	// The flag may only drop after an acknowledge and only rise after an overflow.
	irq_fall_on_ack: assert property (@(posedge clkin_a) disable iff (!rst_n)
		$fell(irq) |-> $past(irq_ack))
		else begin
			$error("irq fell without irq_ack");
			sva_errors++;
		end

	irq_rise_on_overflow: assert property (@(posedge clkin_a) disable iff (!rst_n)
		$rose(irq) |-> $past(overflow))
		else begin
			$error("irq rose without overflow");
			sva_errors++;
		end

endmodule

/* logic/gb_timer_top.sv */
`timescale 1ns/1ps

module gb_timer_top #(
	parameter int APU_TAP_BIT = 12
) (
	input  logic       clkin_a,
	input  logic       rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  logic [3:0] paddr,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic       pready,
	output logic       pslverr,
	input  logic       irq_ack,
	output logic       irq,
	output logic       apu_tick
);

	logic tima_tick;
	logic apu_bit;
	logic overflow;

	timer_regs_if regs_if ();

	apb_timer_regs u_regs (
		.clkin_a (clkin_a),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.regs    (regs_if.regs)
	);

	sys_divider #(
		.APU_TAP_BIT (APU_TAP_BIT)
	) u_divider (
		.clkin_a   (clkin_a),
		.rst_n     (rst_n),
		.core      (regs_if.core),
		.tima_tick (tima_tick),
		.apu_bit   (apu_bit)
	);

	tima_counter u_tima (
		.clkin_a    (clkin_a),
		.rst_n      (rst_n),
		.tima_tick  (tima_tick),
		.tima_wr    (regs_if.tima_wr),
		.tima_wdata (regs_if.tima_wdata),
		.tma        (regs_if.tma),
		.tima_value (regs_if.tima_value),
		.overflow   (overflow)
	);

	timer_irq_out #(
		.APU_TAP_BIT (APU_TAP_BIT)
	) u_irq_out (
		.clkin_a  (clkin_a),
		.rst_n    (rst_n),
		.overflow (overflow),
		.irq_ack  (irq_ack),
		.apu_bit  (apu_bit),
		.irq      (irq),
		.apu_tick (apu_tick)
	);

endmodule

/* logic/timer_irq_out.sv */
`timescale 1ns/1ps

module timer_irq_out #(
	parameter int APU_TAP_BIT = 12
) (
	input  logic clkin_a,
	input  logic rst_n,
	input  logic overflow,
	input  logic irq_ack,
	input  logic apu_bit,
	output logic irq,
	output logic apu_tick
);

	logic apu_prev;

	// The tap has to be a bit of the 16-bit divider.
	if (APU_TAP_BIT < 0 || APU_TAP_BIT > 15) begin : g_bad_tap
		$error("APU_TAP_BIT %0d is outside the divider", APU_TAP_BIT);
	end

	// Interrupt request stays up until acknowledged; a new overflow wins.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n)
			irq <= 1'b0;
		else if (overflow)
			irq <= 1'b1;
		else if (irq_ack)
			irq <= 1'b0;
	end

	// One frame sequencer step per falling edge of the divider tap.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			apu_prev <= 1'b0;
			apu_tick <= 1'b0;
		end else begin
			apu_prev <= apu_bit;
			apu_tick <= apu_prev && !apu_bit;
		end
	end

endmodule

/* logic/tima_counter.sv */
`timescale 1ns/1ps

module tima_counter (
	input  logic       clkin_a,
	input  logic       rst_n,
	input  logic       tima_tick,
	input  logic       tima_wr,
	input  logic [7:0] tima_wdata,
	input  logic [7:0] tma,
	output logic [7:0] tima_value,
	output logic       overflow
);

	logic [7:0] tima_q;
	logic       at_max;

	assign at_max = (tima_q == 8'hFF);

	// A CPU write beats a tick arriving in the same cycle.
	// The reload from TMA happens on the same edge as the wrap.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			tima_q   <= 8'h00;
			overflow <= 1'b0;
		end else if (tima_wr) begin
			tima_q   <= tima_wdata;
			overflow <= 1'b0;
		end else if (tima_tick) begin
			if (at_max) begin
				tima_q   <= tma;
				overflow <= 1'b1;
			end else begin
				tima_q   <= tima_q + 8'd1;
				overflow <= 1'b0;
			end
		end else begin
			overflow <= 1'b0;
		end
	end

	assign tima_value = tima_q;

endmodule

/* logic/sys_divider.sv */
`timescale 1ns/1ps

module sys_divider import gb_timer_pkg::*; #(
	parameter int APU_TAP_BIT = 12
) (
	input  logic       clkin_a,
	input  logic       rst_n,
	timer_regs_if.core core,
	output logic       tima_tick,
	output logic       apu_bit
);

	logic [15:0] div_cnt;
	logic [3:0]  tap_idx;
	logic        tap_level;
	logic        tap_q;

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n)
			div_cnt <= 16'h0000;
		else if (core.div_clear)
			div_cnt <= 16'h0000;
		else
			div_cnt <= div_cnt + 16'd1;
	end

	// DIV is the upper byte of the system counter.
	assign core.div_value = div_cnt[15:8];

	assign tap_idx = tap_bit(core.tac.fields.clk_sel);

	// The tap is gated by enable before edge detection, so clearing DIV or
	// disabling the timer while the tap is high also counts as a falling edge.
	assign tap_level = div_cnt[tap_idx] && core.tac.fields.enable;

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			tap_q     <= 1'b0;
			tima_tick <= 1'b0;
		end else begin
			tap_q     <= tap_level;
			tima_tick <= tap_q && !tap_level;
		end
	end

	assign apu_bit = div_cnt[APU_TAP_BIT];

endmodule

/* logic/apb_timer_regs.sv */
`timescale 1ns/1ps

module apb_timer_regs import gb_timer_pkg::*; (
	input  logic         clkin_a,
	input  logic         rst_n,
	input  logic         psel,
	input  logic         penable,
	input  logic         pwrite,
	input  logic [3:0]   paddr,
	input  logic [7:0]   pwdata,
	output logic [7:0]   prdata,
	output logic         pready,
	output logic         pslverr,
	timer_regs_if.regs   regs
);

	logic      access;
	logic      addr_ok;
	logic      wr_access;
	reg_addr_e addr;
	logic [7:0] tma_q;
	tac_u      tac_q;

	assign access    = psel && penable;
	assign addr_ok   = (paddr[3:2] == 2'b00);
	assign wr_access = access && pwrite && addr_ok;
	assign addr      = reg_addr_e'(paddr[1:0]);

	// Every transfer completes in its first access cycle without wait states.
	assign pready  = 1'b1;
	assign pslverr = access && !addr_ok;

	// Strobes are sampled by the core on the edge that ends the access phase.
	assign regs.div_clear  = wr_access && (addr == REG_DIV);
	assign regs.tima_wr    = wr_access && (addr == REG_TIMA);
	assign regs.tima_wdata = pwdata;

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			tma_q     <= 8'h00;
			tac_q.raw <= 8'h00;
		end else if (wr_access) begin
			if (addr == REG_TMA)
				tma_q <= pwdata;
			if (addr == REG_TAC)
				tac_q.raw <= pwdata & ~TAC_UNUSED_MASK;
		end
	end

	assign regs.tma = tma_q;
	assign regs.tac = tac_q;

	always_comb begin
		prdata = 8'h00;
		if (addr_ok) begin
			case (addr)
				REG_DIV:  prdata = regs.div_value;
				REG_TIMA: prdata = regs.tima_value;
				REG_TMA:  prdata = tma_q;
				REG_TAC:  prdata = tac_q.raw | TAC_UNUSED_MASK;
				default:  prdata = 8'h00;
			endcase
		end
	end

endmodule

/* logic/timer_regs_if.sv */
`timescale 1ns/1ps

interface timer_regs_if import gb_timer_pkg::*; ();

	logic       div_clear;
	logic       tima_wr;
	logic [7:0] tima_wdata;
	logic [7:0] tma;
	tac_u       tac;
	logic [7:0] div_value;
	logic [7:0] tima_value;

	modport regs (
		output div_clear, tima_wr, tima_wdata, tma, tac,
		input  div_value, tima_value
	);

	modport core (
		input  div_clear, tima_wr, tima_wdata, tma, tac,
		output div_value, tima_value
	);

endinterface

/* logic/gb_timer_pkg.sv */
package gb_timer_pkg;

	// Register offsets within the timer block.
	typedef enum logic [1:0] {
		REG_DIV  = 2'd0,
		REG_TIMA = 2'd1,
		REG_TMA  = 2'd2,
		REG_TAC  = 2'd3
	} reg_addr_e;

	typedef struct packed {
		logic [4:0] unused;
		logic       enable;
		logic [1:0] clk_sel;
	} tac_fields_t;

	// The bus sees TAC as a byte, the counters see its fields.
	typedef union packed {
		logic [7:0]  raw;
		tac_fields_t fields;
	} tac_u;

	// Unused TAC bits read back as ones.
	localparam logic [7:0] TAC_UNUSED_MASK = 8'hF8;

	// Divider bit that clocks TIMA for each clock select.
	function automatic logic [3:0] tap_bit(input logic [1:0] clk_sel);
		case (clk_sel)
			2'd0:    tap_bit = 4'd9;
			2'd1:    tap_bit = 4'd3;
			2'd2:    tap_bit = 4'd5;
			default: tap_bit = 4'd7;
		endcase
	endfunction

endpackage
